//--- aluDatapath.f
+incdir+include
logic/isaPkg.sv
logic/statusPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/alu.sv
logic/writeback.sv
logic/cpuCore.sv
tb/coreTb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module coreTb \
	-f aluDatapath.f -o simCore

out=$(./obj_dir/simCore)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
	exit 0
fi
exit 1

//--- tb/coreTb.sv
`default_nettype none
`timescale 1ns/10ps

`include "datapath_macros.svh"

module coreTb;

	////////////////////////////////////////////////////////////////////////////
	// Run length
	////////////////////////////////////////////////////////////////////////////

	// Cycles per test, instructions plus two drain cycles
	localparam int resetLen   = 2;
	localparam int idleLen    = 4;
	localparam int addSubLen  = 17;
	localparam int logicLen   = 31;
	localparam int cmpLen     = 12;
	localparam int chainLen   = 12;
	localparam int totalLen   = resetLen + idleLen + addSubLen + logicLen + cmpLen + chainLen;
	localparam int timeoutLen = 2 * totalLen + 20;

	logic                    clk;
	logic                    rst;
	isaPkg::instrWord_u      instr;
	logic                    instrValid;
	logic                    wbValid;
	logic [`DP_REG_BITS-1:0] wbDest;
	logic [`DP_WIDTH-1:0]    wbData;
	statusPkg::psr_s         psr;

	cpuCore dut_i (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.wbValid    (wbValid),
		.wbDest     (wbDest),
		.wbData     (wbData),
		.psr        (psr)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////////////////////////////////////////

	logic [`DP_WIDTH-1:0]    mReg [`DP_REG_COUNT];
	statusPkg::psr_s         mPsr;

	// Prediction for the instruction driven this cycle
	logic [`DP_WIDTH-1:0]    predData;
	logic [`DP_REG_BITS-1:0] predDest;
	statusPkg::psr_s         predPsr;

	// Prediction moved to the cycle the DUT shows it
	logic                    expValid;
	logic [`DP_WIDTH-1:0]    expData;
	logic [`DP_REG_BITS-1:0] expDest;
	statusPkg::psr_s         expPsr;
	int                      expTestIdx;

	string testNames [5] = '{"reset idle", "imm add sub", "logic mult", "compare", "back to back"};
	isaPkg::aluOp_e chainOps [4] = '{isaPkg::opAdd, isaPkg::opSub, isaPkg::opXor, isaPkg::opMult};

	int curTestIdx = 0;
	int testCount  = 0;
	int errCount   = 0;
	int errStart   = 0;
	int issued     = 0;
	int cycleCount = 0;
	logic [31:0] rngState = 32'h8dca1406;

	always @(posedge clk) begin
		expTestIdx <= curTestIdx;
		if (rst) begin
			expValid <= 1'b0;
			expPsr   <= '0;
		end else begin
			expValid <= instrValid;
			if (instrValid) begin
				expData <= predData;
				expDest <= predDest;
				expPsr  <= predPsr;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output checks, sampled mid-cycle while everything is stable
	////////////////////////////////////////////////////////////////////////////

	aValidCheck: assert property (@(negedge clk) disable iff (rst) wbValid == expValid)
		else begin
			$display("[FAIL] %s wbValid expected %0b actual %0b",
				testNames[expTestIdx], expValid, wbValid);
			errCount++;
		end

	aDataCheck: assert property (@(negedge clk) disable iff (rst)
		wbValid |-> wbData == expData)
		else begin
			$display("[FAIL] %s wbData expected %08h actual %08h",
				testNames[expTestIdx], expData, wbData);
			errCount++;
		end

	aDestCheck: assert property (@(negedge clk) disable iff (rst)
		wbValid |-> wbDest == expDest)
		else begin
			$display("[FAIL] %s wbDest expected %0d actual %0d",
				testNames[expTestIdx], expDest, wbDest);
			errCount++;
		end

	// Also covers the idle cycles after reset
	aPsrCheck: assert property (@(negedge clk) disable iff (rst) psr == expPsr)
		else begin
			$display("[FAIL] %s psr expected %05b actual %05b",
				testNames[expTestIdx], expPsr, psr);
			errCount++;
		end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutLen) begin
			$display("Timeout after %0d cycles, stimulus never finished", cycleCount);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// Drive one instruction at the falling edge and predict its outcome
	task automatic issue(input isaPkg::aluOp_e op, input logic useImm,
		input logic [`DP_REG_BITS-1:0] rd, input logic [`DP_REG_BITS-1:0] rs,
		input logic [`DP_IMM_BITS-1:0] imm8);
		isaPkg::instrWord_u   word;
		logic [`DP_WIDTH-1:0] a;
		logic [`DP_WIDTH-1:0] b;
		logic [`DP_WIDTH-1:0] res;
		logic [`DP_WIDTH:0]   wide;
		statusPkg::psr_s      flags;
		@(negedge clk);
		a     = mReg[rd];
		b     = useImm ? {{(`DP_WIDTH - `DP_IMM_BITS){imm8[`DP_IMM_BITS-1]}}, imm8} : mReg[rs];
		flags = mPsr;
		res   = '0;
		case (op)
			isaPkg::opAdd: begin
				wide    = {1'b0, a} + {1'b0, b};
				res     = wide[`DP_WIDTH-1:0];
				flags.c = wide[`DP_WIDTH];
				flags.f = (a[31] == b[31]) && (res[31] != a[31]);
			end
			isaPkg::opSub: begin
				// Exact signed difference, one bit wider than the data
				wide    = {a[`DP_WIDTH-1], a} - {b[`DP_WIDTH-1], b};
				res     = wide[`DP_WIDTH-1:0];
				flags.c = a < b;
				// Out of signed range when the top two bits disagree
				flags.f = wide[`DP_WIDTH] != wide[`DP_WIDTH-1];
				flags.l = 1'b0;
				flags.z = 1'b0;
				flags.n = 1'b0;
			end
			isaPkg::opOr:   res = a | b;
			isaPkg::opAnd:  res = a & b;
			isaPkg::opXor:  res = a ^ b;
			isaPkg::opNot:  res = ~a;
			isaPkg::opMult: res = a * b;
			default: begin
				// CMP shows the difference only
				res     = a - b;
				flags.l = a < b;
				flags.z = a == b;
				flags.n = $signed(a) < $signed(b);
			end
		endcase
		word = '0;
		if (useImm) begin
			word.immForm.opcode  = op;
			word.immForm.immFlag = 1'b1;
			word.immForm.rd      = rd;
			word.immForm.imm8    = imm8;
		end else begin
			word.regForm.opcode  = op;
			word.regForm.immFlag = 1'b0;
			word.regForm.rd      = rd;
			word.regForm.rs      = rs;
		end
		if (op != isaPkg::opCmp) begin
			mReg[rd] = res;
		end
		mPsr       = flags;
		predData   = res;
		predDest   = rd;
		predPsr    = flags;
		instr      = word;
		instrValid = 1'b1;
		issued++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			instrValid = 1'b0;
			instr      = '0;
		end
	endtask

	task automatic startTest(input int idx);
		curTestIdx = idx;
		errStart   = errCount;
	endtask

	// Two drain cycles so the last result has been checked
	task automatic finishTest();
		idle(2);
		testCount++;
		$display("test %-12s errors %0d", testNames[curTestIdx], errCount - errStart);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0]             r;
		logic [`DP_REG_BITS-1:0] ra;
		logic [`DP_REG_BITS-1:0] rb;
		for (int i = 0; i < `DP_REG_COUNT; i++) begin
			mReg[i] = '0;
		end
		mPsr       = '0;
		rst        = 1'b1;
		instr      = '0;
		instrValid = 1'b0;
		repeat (resetLen) @(negedge clk);
		rst = 1'b0;

		// Nothing issued, outputs stay quiet
		startTest(0);
		idle(2);
		finishTest();

		// Known values, carry, borrow and both overflow cases
		startTest(1);
		issue(isaPkg::opSub, 1'b0, 4'd1, 4'd1, 8'd0);
		issue(isaPkg::opAdd, 1'b1, 4'd1, 4'd0, 8'd100);
		issue(isaPkg::opAdd, 1'b1, 4'd1, 4'd0, 8'hff);
		issue(isaPkg::opSub, 1'b1, 4'd1, 4'd0, 8'd120);
		issue(isaPkg::opSub, 1'b1, 4'd1, 4'd0, 8'hfb);
		issue(isaPkg::opSub, 1'b0, 4'd2, 4'd2, 8'd0);
		issue(isaPkg::opAdd, 1'b1, 4'd2, 4'd0, 8'h80);
		issue(isaPkg::opMult, 1'b0, 4'd2, 4'd2, 8'd0);
		issue(isaPkg::opMult, 1'b0, 4'd2, 4'd2, 8'd0);
		issue(isaPkg::opSub, 1'b0, 4'd3, 4'd3, 8'd0);
		issue(isaPkg::opAdd, 1'b1, 4'd3, 4'd0, 8'd8);
		// r2 becomes 0x80000000
		issue(isaPkg::opMult, 1'b0, 4'd2, 4'd3, 8'd0);
		issue(isaPkg::opSub, 1'b1, 4'd2, 4'd0, 8'd1);
		issue(isaPkg::opAdd, 1'b1, 4'd2, 4'd0, 8'd1);
		r = nextRand();
		issue(isaPkg::opAdd, 1'b1, 4'd2, 4'd0, r[7:0]);
		finishTest();

		// Seed r8..r11, then random register-form logic and MULT
		startTest(2);
		for (int i = 8; i < 12; i++) begin
			ra = 4'(i);
			r  = nextRand();
			issue(isaPkg::opSub, 1'b0, ra, ra, 8'd0);
			issue(isaPkg::opAdd, 1'b1, ra, 4'd0, r[7:0]);
			issue(isaPkg::opMult, 1'b0, ra, ra, 8'd0);
			issue(isaPkg::opMult, 1'b0, ra, ra, 8'd0);
		end
		// Leave l and n set for the PSR hold checks
		issue(isaPkg::opCmp, 1'b1, 4'd0, 4'd0, 8'd1);
		repeat (12) begin
			r  = nextRand();
			ra = {2'b10, r[1:0]};
			rb = {2'b10, r[3:2]};
			issue(isaPkg::aluOp_e'(3'(32'd2 + (r[31:8] % 32'd5))), 1'b0, ra, rb, 8'd0);
		end
		finishTest();

		// Equal, unsigned-less and signed-less pairs, then read back
		startTest(3);
		issue(isaPkg::opSub, 1'b0, 4'd5, 4'd5, 8'd0);
		issue(isaPkg::opAdd, 1'b1, 4'd5, 4'd0, 8'd5);
		issue(isaPkg::opSub, 1'b0, 4'd6, 4'd6, 8'd0);
		issue(isaPkg::opAdd, 1'b1, 4'd6, 4'd0, 8'hfd);
		issue(isaPkg::opCmp, 1'b0, 4'd5, 4'd5, 8'd0);
		issue(isaPkg::opCmp, 1'b0, 4'd5, 4'd6, 8'd0);
		issue(isaPkg::opCmp, 1'b0, 4'd6, 4'd5, 8'd0);
		issue(isaPkg::opCmp, 1'b1, 4'd5, 4'd0, 8'd5);
		issue(isaPkg::opAdd, 1'b1, 4'd5, 4'd0, 8'd0);
		issue(isaPkg::opAdd, 1'b1, 4'd6, 4'd0, 8'd0);
		finishTest();

		// Every instruction reuses r7 from the one before
		startTest(4);
		r = nextRand();
		issue(isaPkg::opAdd, 1'b1, 4'd7, 4'd0, r[7:0]);
		for (int i = 0; i < 9; i++) begin
			r = nextRand();
			issue(chainOps[r[1:0]], 1'(i % 2), 4'd7, 4'd7, r[15:8]);
		end
		finishTest();

		$display("tests %0d  instructions %0d  errors %0d", testCount, issued, errCount);
		if (errCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/cpuCore.sv
`default_nettype none
`timescale 1ns/10ps

`include "datapath_macros.svh"

module cpuCore (
	input  logic                    clk,
	input  logic                    rst,
	input  isaPkg::instrWord_u      instr,
	input  logic                    instrValid,
	output logic                    wbValid,
	output logic [`DP_REG_BITS-1:0] wbDest,
	output logic [`DP_WIDTH-1:0]    wbData,
	output statusPkg::psr_s         psr
);

	////////////////////////////////////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////////////////////////////////////

	isaPkg::ctrl_s           ctrl;
	logic [`DP_WIDTH-1:0]    rdData;
	logic [`DP_WIDTH-1:0]    rsData;
	logic [`DP_WIDTH-1:0]    result;
	statusPkg::flagUpdate_s  flagUpd;
	logic                    wrEn;
	logic [`DP_REG_BITS-1:0] wrAddr;
	logic [`DP_WIDTH-1:0]    wrData;

	// Decode, all combinational
	instrDecode decode_i (
		.instr      (instr),
		.instrValid (instrValid),
		.ctrl       (ctrl)
	);

	// Operand fetch and commit target
	regFile regFile_i (
		.clk    (clk),
		.rst    (rst),
		.rdAddr (ctrl.rdAddr),
		.rsAddr (ctrl.rsAddr),
		.rdData (rdData),
		.rsData (rsData),
		.wrEn   (wrEn),
		.wrAddr (wrAddr),
		.wrData (wrData)
	);

	// Operand select lives inside the ALU
	alu alu_i (
		.ctrl    (ctrl),
		.rdData  (rdData),
		.rsData  (rsData),
		.result  (result),
		.flagUpd (flagUpd)
	);

	// Commit, PSR and observed outputs
	writeback writeback_i (
		.clk     (clk),
		.rst     (rst),
		.ctrl    (ctrl),
		.result  (result),
		.flagUpd (flagUpd),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.wbValid (wbValid),
		.wbDest  (wbDest),
		.wbData  (wbData),
		.psr     (psr)
	);

endmodule

`default_nettype wire

//--- logic/writeback.sv
`default_nettype none
`timescale 1ns/10ps

`include "datapath_macros.svh"

module writeback (
	input  logic                    clk,
	input  logic                    rst,
	input  isaPkg::ctrl_s           ctrl,
	input  logic [`DP_WIDTH-1:0]    result,
	input  statusPkg::flagUpdate_s  flagUpd,
	output logic                    wrEn,
	output logic [`DP_REG_BITS-1:0] wrAddr,
	output logic [`DP_WIDTH-1:0]    wrData,
	output logic                    wbValid,
	output logic [`DP_REG_BITS-1:0] wbDest,
	output logic [`DP_WIDTH-1:0]    wbData,
	output statusPkg::psr_s         psr
);

	////////////////////////////////////////////////////////////////////////
	// Register file write, same cycle
	////////////////////////////////////////////////////////////////////////

	// regWrite already excludes CMP
	assign wrEn   = ctrl.valid && ctrl.regWrite;
	assign wrAddr = ctrl.rdAddr;
	assign wrData = result;

	////////////////////////////////////////////////////////////////////////
	// PSR merge
	////////////////////////////////////////////////////////////////////////

	statusPkg::psr_s psrNext;

	// Per flag, new value where masked, old value elsewhere
	always_comb begin
		psrNext.c = flagUpd.mask.c ? flagUpd.flags.c : psr.c;
		psrNext.l = flagUpd.mask.l ? flagUpd.flags.l : psr.l;
		psrNext.f = flagUpd.mask.f ? flagUpd.flags.f : psr.f;
		psrNext.z = flagUpd.mask.z ? flagUpd.flags.z : psr.z;
		psrNext.n = flagUpd.mask.n ? flagUpd.flags.n : psr.n;
	end

	// Control state
	always_ff @(posedge clk) begin
		if (rst) begin
			wbValid <= 1'b0;
			psr     <= '0;
		end else begin
			wbValid <= ctrl.valid;
			if (ctrl.valid) begin
				psr <= psrNext;
			end
		end
	end

	// Observed result, shown the cycle after issue
	always_ff @(posedge clk) begin
		if (ctrl.valid) begin
			wbDest <= ctrl.rdAddr;
			wbData <= result;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////

	aUnmaskedHold: assert property (@(posedge clk) disable iff (rst)
		ctrl.valid |=> (((psr ^ $past(psr)) & ~$past(flagUpd.mask)) == '0))
		else $error("writeback: unmasked PSR bit changed");

	aWbValidFollows: assert property (@(posedge clk) disable iff (rst)
		ctrl.valid |=> wbValid)
		else $error("writeback: wbValid missing after valid");

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none
`timescale 1ns/10ps

`include "datapath_macros.svh"

module alu (
	input  isaPkg::ctrl_s          ctrl,
	input  logic [`DP_WIDTH-1:0]   rdData,
	input  logic [`DP_WIDTH-1:0]   rsData,
	output logic [`DP_WIDTH-1:0]   result,
	output statusPkg::flagUpdate_s flagUpd
);

	////////////////////////////////////////////////////////////////////////
	// Operands
	////////////////////////////////////////////////////////////////////////

	logic [`DP_WIDTH-1:0] arg1;
	logic [`DP_WIDTH-1:0] arg2;

	// rd is always the first source
	assign arg1 = rdData;
	// Immediate or rs
	assign arg2 = ctrl.useImm ? ctrl.immValue : rsData;

	////////////////////////////////////////////////////////////////////////
	// Arithmetic and compare
	////////////////////////////////////////////////////////////////////////

	// Extra bit holds the carry out
	logic [`DP_WIDTH:0]   sum;
	logic [`DP_WIDTH-1:0] diff;
	logic [`DP_WIDTH-1:0] product;

	logic addOvf;
	logic subOvf;
	logic ltUnsigned;
	logic ltSigned;
	logic equal;

	assign sum  = {1'b0, arg1} + {1'b0, arg2};
	assign diff = arg1 - arg2;
	// Low half of the product only
	assign product = arg1 * arg2;

	// ADD overflow, same-signed operands and a sum of the other sign
	assign addOvf = (arg1[`DP_WIDTH-1] == arg2[`DP_WIDTH-1]) &&
		(sum[`DP_WIDTH-1] != arg1[`DP_WIDTH-1]);

	// SUB overflow, operand signs differ and result sign leaves arg1
	assign subOvf = (arg1[`DP_WIDTH-1] != arg2[`DP_WIDTH-1]) &&
		(diff[`DP_WIDTH-1] != arg1[`DP_WIDTH-1]);

	// Comparators, also the SUB borrow
	assign ltUnsigned = arg1 < arg2;
	assign ltSigned   = $signed(arg1) < $signed(arg2);
	assign equal      = arg1 == arg2;

	////////////////////////////////////////////////////////////////////////
	// Result and flag update
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		result  = sum[`DP_WIDTH-1:0];
		flagUpd = statusPkg::noFlagUpdate;
		case (ctrl.op)
			isaPkg::opAdd: begin
				result          = sum[`DP_WIDTH-1:0];
				flagUpd.flags.c = sum[`DP_WIDTH];
				flagUpd.flags.f = addOvf;
				flagUpd.mask.c  = 1'b1;
				flagUpd.mask.f  = 1'b1;
			end
			isaPkg::opSub: begin
				result = diff;
				// Carry is the borrow, l z n go to zero
				flagUpd.flags.c = ltUnsigned;
				flagUpd.flags.f = subOvf;
				flagUpd.mask    = '1;
			end
			isaPkg::opOr:   result = arg1 | arg2;
			isaPkg::opAnd:  result = arg1 & arg2;
			isaPkg::opXor:  result = arg1 ^ arg2;
			// Single operand
			isaPkg::opNot:  result = ~arg1;
			isaPkg::opMult: result = product;
			isaPkg::opCmp: begin
				// Difference goes out for observation, never written
				result          = diff;
				flagUpd.flags.l = ltUnsigned;
				flagUpd.flags.z = equal;
				flagUpd.flags.n = ltSigned;
				flagUpd.mask.l  = 1'b1;
				flagUpd.mask.z  = 1'b1;
				flagUpd.mask.n  = 1'b1;
			end
			default: result = sum[`DP_WIDTH-1:0];
		endcase
	end

	////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////

	// Logic ops and MULT leave the PSR alone
	always_comb begin
		if (ctrl.valid && (ctrl.op inside {isaPkg::opOr, isaPkg::opAnd,
			isaPkg::opXor, isaPkg::opNot, isaPkg::opMult})) begin
			assert (flagUpd.mask == '0)
				else $error("alu: flag mask set for op %0d", ctrl.op);
		end
	end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`default_nettype none
`timescale 1ns/10ps

`include "datapath_macros.svh"

module regFile (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`DP_REG_BITS-1:0] rdAddr,
	input  logic [`DP_REG_BITS-1:0] rsAddr,
	output logic [`DP_WIDTH-1:0]    rdData,
	output logic [`DP_WIDTH-1:0]    rsData,
	input  logic                    wrEn,
	input  logic [`DP_REG_BITS-1:0] wrAddr,
	input  logic [`DP_WIDTH-1:0]    wrData
);

	////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////

	// 16 x 32 general registers
	logic [`DP_WIDTH-1:0] regs [`DP_REG_COUNT];

	// All registers cleared on reset
	// Single write port, commits at the edge ending the cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DP_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////

	// Combinational, value after the last edge
	// No bypass needed, the write lands before the next instruction reads
	assign rdData = regs[rdAddr];
	assign rsData = regs[rsAddr];

endmodule

`default_nettype wire

//--- logic/instrDecode.sv
`default_nettype none
`timescale 1ns/10ps

`include "datapath_macros.svh"

module instrDecode (
	input  isaPkg::instrWord_u instr,
	input  logic               instrValid,
	output isaPkg::ctrl_s      ctrl
);

	////////////////////////////////////////////////////////////////////////
	// Field extraction
	////////////////////////////////////////////////////////////////////////

	// Shared by both views
	logic                    immSel;
	isaPkg::aluOp_e          opcode;
	logic [`DP_REG_BITS-1:0] rdField;

	// Immediate view only
	logic [`DP_IMM_BITS-1:0] immRaw;
	logic [`DP_WIDTH-1:0]    immExt;

	// Register view only
	logic [`DP_REG_BITS-1:0] rsField;

	// immFlag is common to both views, read it through either one
	assign immSel  = instr.immForm.immFlag;
	assign opcode  = instr.immForm.opcode;
	assign rdField = instr.immForm.rd;

	assign immRaw = instr.immForm.imm8;
	assign rsField = instr.regForm.rs;

	// Sign extension of imm8
	assign immExt = {{(`DP_WIDTH - `DP_IMM_BITS){immRaw[`DP_IMM_BITS-1]}}, immRaw};

	////////////////////////////////////////////////////////////////////////
	// Control word
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl.op     = opcode;
		ctrl.rdAddr = rdField;
		// rs is don't-care for the immediate form, ALU ignores it
		ctrl.rsAddr = rsField;
		ctrl.useImm = immSel;
		// Zero when unused, keeps the bus quiet
		ctrl.immValue = immSel ? immExt : '0;
		ctrl.valid    = instrValid;
		// CMP only sets flags
		ctrl.regWrite = instrValid && (opcode != isaPkg::opCmp);
	end

	////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////

	// Nothing downstream may act on an idle cycle
	always_comb begin
		if (!instrValid) begin
			assert (!ctrl.valid && !ctrl.regWrite)
				else $error("instrDecode: valid or regWrite without instrValid");
		end
	end

endmodule

`default_nettype wire

//--- logic/statusPkg.sv
`default_nettype none

package statusPkg;

	////////////////////////////////////////////////////////////////////////
	// Program status register
	////////////////////////////////////////////////////////////////////////

	// Same bit order as the old PSRwrite vector, {C,L,F,Z,N}
	typedef struct packed {
		// Carry out of ADD, borrow of SUB
		logic c;
		// Unsigned less-than from CMP
		logic l;
		// Signed overflow
		logic f;
		// Operands equal
		logic z;
		// Signed less-than from CMP
		logic n;
	} psr_s;

	////////////////////////////////////////////////////////////////////////
	// Flag update from the ALU
	////////////////////////////////////////////////////////////////////////

	// New flag values plus a per-flag write mask
	// Flags with a clear mask bit keep their PSR value
	typedef struct packed {
		psr_s flags;
		psr_s mask;
	} flagUpdate_s;

	// No flag touched
	localparam flagUpdate_s noFlagUpdate = '0;

endpackage

`default_nettype wire

//--- logic/isaPkg.sv
`default_nettype none

`include "datapath_macros.svh"

package isaPkg;

	////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////

	// Encoding matches the existing ALU opcode map
	typedef enum logic [`DP_OP_BITS-1:0] {
		opAdd  = 3'd0,
		opSub  = 3'd1,
		opOr   = 3'd2,
		opAnd  = 3'd3,
		opXor  = 3'd4,
		opNot  = 3'd5,
		opMult = 3'd6,
		opCmp  = 3'd7
	} aluOp_e;

	////////////////////////////////////////////////////////////////////////
	// Instruction word, two views of the same 16 bits
	////////////////////////////////////////////////////////////////////////

	// Register form, second operand from rs
	typedef struct packed {
		aluOp_e                    opcode;
		logic                      immFlag;
		logic [`DP_REG_BITS-1:0]   rd;
		logic [`DP_REG_BITS-1:0]   rs;
		logic [`DP_SPARE_BITS-1:0] spare;
	} regForm_s;

	// Immediate form, second operand is imm8
	typedef struct packed {
		aluOp_e                  opcode;
		logic                    immFlag;
		logic [`DP_REG_BITS-1:0] rd;
		logic [`DP_IMM_BITS-1:0] imm8;
	} immForm_s;

	// immFlag sits at bit 12 in both views
	typedef union packed {
		regForm_s regForm;
		immForm_s immForm;
	} instrWord_u;

	////////////////////////////////////////////////////////////////////////
	// Decoded control
	////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		aluOp_e                  op;
		logic [`DP_REG_BITS-1:0] rdAddr;
		logic [`DP_REG_BITS-1:0] rsAddr;
		logic                    useImm;
		// Already sign-extended
		logic [`DP_WIDTH-1:0]    immValue;
		logic                    regWrite;
		logic                    valid;
	} ctrl_s;

endpackage

`default_nettype wire

//--- include/datapath_macros.svh
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Data word and ALU operand width
`define DP_WIDTH 32

// Register file depth and address width
`define DP_REG_COUNT 16
`define DP_REG_BITS 4

// Short immediate, sign-extended to DP_WIDTH in decode
`define DP_IMM_BITS 8

////////////////////////////////////////////////////////////////////////////
// Instruction word layout
////////////////////////////////////////////////////////////////////////////

// Full instruction word
`define DP_INSTR_BITS 16

// Opcode field, eight ALU operations
`define DP_OP_BITS 3

// Unused low bits of the register form
`define DP_SPARE_BITS 4

`endif
